// ==== Makefile ====
# Verilator build and run of the hit-timing testbench

VERILATOR ?= verilator
TOP       ?= fineTimeTb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert
RUN_ARGS  ?= +verilator+error+limit+100
FAIL_MSG  := >>> FAIL
PASS_MSG  := >>> PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) 2>&1 | tee $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then \
	    echo "Simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -qF '$(PASS_MSG)' $(LOG); then \
	    echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== sources.f ====
verilog/fineTimePkg.sv
verilog/busControl.sv
verilog/hitChannel.sv
verilog/particleCombiner.sv
verilog/testMux.sv
verilog/fineTimeTop.sv
verif/fineTime_assertions.sv
verif/fineTimeTb.sv

// ==== verif/fineTimeTb.sv ====
// Testbench for the hit-timing and particle-flag block
// Bus and pulse stimulus, reference flag model, summary comparator
// Hit count and window models, test report and cycle timeout
`timescale 1ns/1ps

module fineTimeTb import fineTimePkg::*; ();

    localparam int NumChannels   = 48;
    localparam int GroupSize     = 8;
    localparam int TimeoutCycles = 4000;

    logic                   clk = 1'b0;
    logic                   arstN;
    logic [NumChannels-1:0] dIn;
    localBus_t              bus;
    logic [BusW-1:0]        dataOut;
    logic [5:0]             testChNum;
    logic [TimeW-1:0]       result;
    pidSummary_t            summary;

    int          seed = 32'h8e85;
    int          cycle = 0;
    int          checkCount = 0;
    int          errorCount = 0;
    int          cmpChecks = 0;
    int          cmpErrors = 0;
    int          lastRise = 0;
    int          modelCount [NumChannels];
    pidWindows_t modelWin = WinDefaults;
    int          expCycleQ [$];
    pidSummary_t expSummaryQ [$];

    fineTimeTop #(.NumChannels(NumChannels), .GroupSize(GroupSize)) DUT (
        .clk       (clk),
        .arstN     (arstN),
        .dIn       (dIn),
        .bus       (bus),
        .dataOut   (dataOut),
        .testChNum (testChNum),
        .result    (result),
        .summary   (summary)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= TimeoutCycles) begin
            $display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
            $display(">>> FAIL");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------------
    function automatic pidFlags_t expectFlags(input int width, input pidWindows_t win);
        pidFlags_t f;
        int        w;
        // Width counter saturates
        w = (width > 255) ? 255 : width;
        f.electron = (w >= int'(win.electronLo)) && (w <= int'(win.electronHi));
        f.muon     = (w >= int'(win.muonLo)) && (w <= int'(win.muonHi));
        f.pion     = (w >= int'(win.pionLo)) && (w <= int'(win.pionHi));
        return f;
    endfunction

    // Groups 0 and 2 are up, 1 and 3 down, 4 and 5 only reach the totals
    function automatic pidSummary_t expectSummary(input logic [NumChannels-1:0] mask,
                                                  input int width, input pidWindows_t win);
        pidFlags_t f;
        logic      anyHit;
        logic      upHit;
        logic      downHit;
        f       = expectFlags(width, win);
        anyHit  = |mask;
        upHit   = 1'b0;
        downHit = 1'b0;
        for (int c = 0; c < NumChannels; c++) begin
            upHit   |= mask[c] && (c / GroupSize == 0 || c / GroupSize == 2);
            downHit |= mask[c] && (c / GroupSize == 1 || c / GroupSize == 3);
        end
        return {f.electron & anyHit, f.muon & anyHit, f.pion & anyHit,
                f.electron & upHit, f.electron & downHit, f.muon & upHit,
                f.muon & downHit, f.pion & upHit, f.pion & downHit};
    endfunction

    // Window register a, in address order from electron low to pion high
    function automatic logic [BusW-1:0] winField(input pidWindows_t win, input int a);
        return BusW'(win[(5 - a) * WidthW +: WidthW]);
    endfunction

    function automatic int totalErrors();
        return errorCount + cmpErrors;
    endfunction

    // ------------------------------------------------------------------------
    // Stimulus and checking tasks
    // ------------------------------------------------------------------------
    task automatic nextCycle();
        @(posedge clk);
        #2;
    endtask

    task automatic checkEqual(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("ERROR @%0t: %s got 0x%0h, expected 0x%0h", $time, what, got, exp);
        end
    endtask

    task automatic busWrite(input logic [AddrW-1:0] addr, input logic [BusW-1:0] data);
        bus = '{address: addr, dataIn: data, read: 1'b0, write: 1'b1};
        nextCycle();
        bus = '0;
    endtask

    task automatic busRead(input logic [AddrW-1:0] addr, output logic [BusW-1:0] data);
        bus = '{address: addr, dataIn: '0, read: 1'b1, write: 1'b0};
        nextCycle();
        data = dataOut;
        bus  = '0;
    endtask

    task automatic pulseChannels(input logic [NumChannels-1:0] mask, input int width);
        dIn      = mask;
        lastRise = cycle;
        repeat (width) nextCycle();
        dIn = '0;
        // Summary shows up 4 cycles after the fall
        expCycleQ.push_back(cycle + 4);
        expSummaryQ.push_back(expectSummary(mask, width, modelWin));
        for (int c = 0; c < NumChannels; c++) begin
            if (mask[c]) modelCount[c]++;
        end
        repeat (6) nextCycle();
    endtask

    task automatic checkAllCounts(input string what);
        logic [BusW-1:0] data;
        for (int k = 0; k < NumChannels; k++) begin
            busRead(ChanBase + AddrW'(k), data);
            checkEqual($sformatf("%s ch%0d", what, k), data, modelCount[k]);
        end
    endtask

    task automatic reportTest(input string name, input int errorsBefore);
        if (totalErrors() == errorsBefore) begin
            $display("Test %-20s ok", name);
        end else begin
            $display("Test %-20s %0d errors", name, totalErrors() - errorsBefore);
        end
    endtask

    // Summary must match the queued expectation and be zero otherwise
    always @(negedge clk) begin
        if (arstN) begin
            if (expCycleQ.size() > 0 && expCycleQ[0] == cycle) begin
                cmpChecks++;
                if (summary !== expSummaryQ[0]) begin
                    cmpErrors++;
                    $display("ERROR @%0t: summary got 0x%0h, expected 0x%0h",
                             $time, summary, expSummaryQ[0]);
                end
                void'(expCycleQ.pop_front());
                void'(expSummaryQ.pop_front());
            end else if (summary != '0) begin
                cmpErrors++;
                $display("ERROR @%0t: summary 0x%0h with no pulse pending", $time, summary);
            end
        end
    end

    // ------------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------------
    initial begin
        logic [BusW-1:0]        data;
        logic [TimeW-1:0]       firstStamp;
        logic [NumChannels-1:0] mask;
        int                     startErrors;
        int                     width;
        int                     ch;
        int                     riseA;

        arstN     = 1'b0;
        dIn       = '0;
        bus       = '0;
        testChNum = '0;
        for (int k = 0; k < NumChannels; k++) modelCount[k] = 0;
        repeat (16) @(posedge clk);
        #2;
        arstN = 1'b1;

        startErrors = totalErrors();
        checkEqual("summary after reset", 32'(summary), 0);
        checkEqual("result after reset", result, 0);
        checkEqual("dataOut after reset", dataOut, 0);
        for (int a = 0; a < 6; a++) begin
            busRead(AddrW'(a), data);
            checkEqual($sformatf("window %0d default", a), data, winField(modelWin, a));
        end
        checkAllCounts("count after reset");
        reportTest("reset state", startErrors);

        startErrors = totalErrors();
        for (int a = 0; a < 6; a++) begin
            data = $random(seed);
            busWrite(AddrW'(a), data);
            modelWin[(5 - a) * WidthW +: WidthW] = data[WidthW-1:0];
        end
        for (int a = 0; a < 6; a++) begin
            busRead(AddrW'(a), data);
            checkEqual($sformatf("window %0d readback", a), data, winField(modelWin, a));
        end
        for (int a = 0; a < 6; a++) busWrite(AddrW'(a), winField(WinDefaults, a));
        modelWin = WinDefaults;
        reportTest("window access", startErrors);

        startErrors = totalErrors();
        repeat (24) begin
            width = 1 + int'($unsigned($random(seed)) % 24);
            ch    = int'($unsigned($random(seed)) % NumChannels);
            pulseChannels(NumChannels'(1) << ch, width);
        end
        reportTest("single pulses", startErrors);

        startErrors = totalErrors();
        repeat (4) begin
            mask  = NumChannels'({$random(seed), $random(seed)});
            width = 1 + int'($unsigned($random(seed)) % 24);
            pulseChannels(mask, width);
        end
        // Every channel ends up with a nonzero count
        width = 1 + int'($unsigned($random(seed)) % 24);
        pulseChannels('1, width);
        checkAllCounts("hit count");
        ch = int'($unsigned($random(seed)) % NumChannels);
        busWrite(ChanBase + AddrW'(ch), '0);
        modelCount[ch] = 0;
        checkAllCounts("count after clear");
        reportTest("hit counts", startErrors);

        startErrors = totalErrors();
        ch        = int'($unsigned($random(seed)) % NumChannels);
        testChNum = 6'(ch);
        pulseChannels(NumChannels'(1) << ch, 2);
        riseA      = lastRise;
        firstStamp = result;
        repeat (int'($unsigned($random(seed)) % 32)) nextCycle();
        pulseChannels(NumChannels'(1) << ch, 3);
        checkEqual("stamp difference", result - firstStamp, TimeW'(lastRise - riseA));
        testChNum = 6'(48 + int'($unsigned($random(seed)) % 16));
        repeat (3) nextCycle();
        checkEqual("result for unused select", result, 0);
        reportTest("time stamps", startErrors);

        if (expCycleQ.size() != 0) begin
            errorCount++;
            $display("%0d expected summary pulses never arrived", expCycleQ.size());
        end
        errorCount += DUT.uFineTimeAssertions.failCount;
        $display("Checks %0d, errors %0d, assertion failures %0d",
                 checkCount + cmpChecks, totalErrors(), DUT.uFineTimeAssertions.failCount);
        if (totalErrors() == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== verif/fineTime_assertions.sv ====
// Concurrent checks on the summary flags and the bus read data
// Bound into fineTimeTop
`timescale 1ns/1ps

module fineTimeAssertions import fineTimePkg::*; #(
    parameter int NumChannels = 48
) (
    input logic                   clk,
    input logic                   arstN,
    input logic [NumChannels-1:0] dIn,
    input localBus_t              bus,
    input logic [BusW-1:0]        dataOut,
    input pidSummary_t            summary
);

    int failCount = 0;

    // One-cycle summary pulse once the inputs are quiet
    summaryOneCycle: assert property (@(posedge clk) disable iff (!arstN)
        (summary != '0 && dIn == '0 && $past(dIn, 1) == '0 && $past(dIn, 2) == '0
         && $past(dIn, 3) == '0 && $past(dIn, 4) == '0) |=> summary == '0)
        else begin
            failCount++;
            $error("summary high for two cycles with quiet inputs");
        end

    upDownImpliesTotal: assert property (@(posedge clk) disable iff (!arstN)
        ((summary.electronUp || summary.electronDown) -> summary.electron)
        && ((summary.muonUp || summary.muonDown) -> summary.muon)
        && ((summary.pionUp || summary.pionDown) -> summary.pion))
        else begin
            failCount++;
            $error("up or down flag without the matching total");
        end

    dataOutIdle: assert property (@(posedge clk) disable iff (!arstN)
        !bus.read |=> dataOut == '0)
        else begin
            failCount++;
            $error("dataOut nonzero after a cycle without read");
        end

endmodule

bind fineTimeTop fineTimeAssertions #(.NumChannels(NumChannels)) uFineTimeAssertions (
    .clk     (clk),
    .arstN   (arstN),
    .dIn     (dIn),
    .bus     (bus),
    .dataOut (dataOut),
    .summary (summary)
);

// ==== verilog/busControl.sv ====
// Local bus decoder with the six window registers
// Free-running coarse time counter shared by all channels
// Registered readback of windows and per-channel hit counts
`timescale 1ns/1ps

module busControl import fineTimePkg::*; #(
    parameter int NumChannels = 48
) (
    input  logic                                clk,
    input  logic                                arstN,
    input  localBus_t                           bus,
    input  logic [NumChannels-1:0][CountW-1:0]  hitCounts,
    output pidWindows_t                         windows,
    output logic [TimeW-1:0]                    timeNow,
    output logic [NumChannels-1:0]              countClear,
    output logic [BusW-1:0]                     dataOut
);

    logic [CountW-1:0] countRead;
    logic [BusW-1:0]   readData;

    // ------------------------------------------------------------------------
    // Channel count decode
    // ------------------------------------------------------------------------
    always_comb begin
        countRead  = '0;
        countClear = '0;
        for (int k = 0; k < NumChannels; k++) begin
            if (bus.address == AddrW'(ChanBase + k)) begin
                countRead     = hitCounts[k];
                countClear[k] = bus.write;
            end
        end
    end

    always_comb begin
        case (bus.address)
            WinElectronLo: readData = BusW'(windows.electronLo);
            WinElectronHi: readData = BusW'(windows.electronHi);
            WinMuonLo:     readData = BusW'(windows.muonLo);
            WinMuonHi:     readData = BusW'(windows.muonHi);
            WinPionLo:     readData = BusW'(windows.pionLo);
            WinPionHi:     readData = BusW'(windows.pionHi);
            // Zero when no channel matched either
            default:       readData = BusW'(countRead);
        endcase
    end

    // ------------------------------------------------------------------------
    // Window registers
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            windows <= WinDefaults;
        end else if (bus.write) begin
            case (bus.address)
                WinElectronLo: windows.electronLo <= bus.dataIn[WidthW-1:0];
                WinElectronHi: windows.electronHi <= bus.dataIn[WidthW-1:0];
                WinMuonLo:     windows.muonLo     <= bus.dataIn[WidthW-1:0];
                WinMuonHi:     windows.muonHi     <= bus.dataIn[WidthW-1:0];
                WinPionLo:     windows.pionLo     <= bus.dataIn[WidthW-1:0];
                WinPionHi:     windows.pionHi     <= bus.dataIn[WidthW-1:0];
                default: ;
            endcase
        end
    end

    // Coarse time
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            timeNow <= '0;
        end else begin
            timeNow <= timeNow + 1'b1;
        end
    end

    // Read data one cycle after the strobe, zero otherwise
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            dataOut <= '0;
        end else if (bus.read) begin
            dataOut <= readData;
        end else begin
            dataOut <= '0;
        end
    end

endmodule

// ==== verilog/fineTimePkg.sv ====
// Shared widths, bus address map and packed types for the hit-timing block
// Window reset defaults for the electron, muon and pion classifiers
package fineTimePkg;

    localparam int WidthW = 8;
    localparam int TimeW  = 32;
    localparam int BusW   = 32;
    localparam int AddrW  = 8;
    localparam int CountW = 16;

    // Register map
    localparam logic [AddrW-1:0] WinElectronLo = 8'h00;
    localparam logic [AddrW-1:0] WinElectronHi = 8'h01;
    localparam logic [AddrW-1:0] WinMuonLo     = 8'h02;
    localparam logic [AddrW-1:0] WinMuonHi     = 8'h03;
    localparam logic [AddrW-1:0] WinPionLo     = 8'h04;
    localparam logic [AddrW-1:0] WinPionHi     = 8'h05;
    localparam logic [AddrW-1:0] ChanBase      = 8'h40;

    typedef struct packed {
        logic [AddrW-1:0] address;
        logic [BusW-1:0]  dataIn;
        logic             read;
        logic             write;
    } localBus_t;

    typedef struct packed {
        logic [WidthW-1:0] electronLo;
        logic [WidthW-1:0] electronHi;
        logic [WidthW-1:0] muonLo;
        logic [WidthW-1:0] muonHi;
        logic [WidthW-1:0] pionLo;
        logic [WidthW-1:0] pionHi;
    } pidWindows_t;

    typedef struct packed {
        logic electron;
        logic muon;
        logic pion;
    } pidFlags_t;

    typedef struct packed {
        logic electron;
        logic muon;
        logic pion;
        logic electronUp;
        logic electronDown;
        logic muonUp;
        logic muonDown;
        logic pionUp;
        logic pionDown;
    } pidSummary_t;

    localparam pidWindows_t WinDefaults = '{
        electronLo: 8'd2,  electronHi: 8'd4,
        muonLo:     8'd6,  muonHi:     8'd10,
        pionLo:     8'd12, pionHi:     8'd20
    };

endpackage

// ==== verilog/fineTimeTop.sv ====
// Top level of the hit-timing and particle-flag block
// Bus control, one hitChannel per input, flag combiner and test mux
`timescale 1ns/1ps

module fineTimeTop import fineTimePkg::*; #(
    parameter int NumChannels = 48,
    parameter int GroupSize   = 8
) (
    input  logic                   clk,
    input  logic                   arstN,
    input  logic [NumChannels-1:0] dIn,
    input  localBus_t              bus,
    output logic [BusW-1:0]        dataOut,
    input  logic [5:0]             testChNum,
    output logic [TimeW-1:0]       result,
    output pidSummary_t            summary
);

    pidWindows_t                        windows;
    logic [TimeW-1:0]                   timeNow;
    logic [NumChannels-1:0]             countClear;
    pidFlags_t [NumChannels-1:0]        flags;
    logic [NumChannels-1:0][TimeW-1:0]  stamps;
    logic [NumChannels-1:0][CountW-1:0] hitCounts;

    busControl #(.NumChannels(NumChannels)) uBusControl (
        .clk        (clk),
        .arstN      (arstN),
        .bus        (bus),
        .hitCounts  (hitCounts),
        .windows    (windows),
        .timeNow    (timeNow),
        .countClear (countClear),
        .dataOut    (dataOut)
    );

    for (genvar ch = 0; ch < NumChannels; ch++) begin : gChannel
        hitChannel uHitChannel (
            .clk        (clk),
            .arstN      (arstN),
            .dIn        (dIn[ch]),
            .windows    (windows),
            .timeNow    (timeNow),
            .countClear (countClear[ch]),
            .flags      (flags[ch]),
            .stamp      (stamps[ch]),
            .hitCount   (hitCounts[ch])
        );
    end

    particleCombiner #(
        .NumChannels (NumChannels),
        .GroupSize   (GroupSize)
    ) uParticleCombiner (
        .clk     (clk),
        .arstN   (arstN),
        .flags   (flags),
        .summary (summary)
    );

    testMux #(.NumChannels(NumChannels)) uTestMux (
        .clk       (clk),
        .arstN     (arstN),
        .stamps    (stamps),
        .testChNum (testChNum),
        .result    (result)
    );

endmodule

// ==== verilog/hitChannel.sv ====
// One discriminator channel
// Two-flop synchronizer, edge detect and saturating width counter
// Rise time stamp, particle window classifier and hit counter
`timescale 1ns/1ps

module hitChannel import fineTimePkg::*; (
    input  logic              clk,
    input  logic              arstN,
    input  logic              dIn,
    input  pidWindows_t       windows,
    input  logic [TimeW-1:0]  timeNow,
    input  logic              countClear,
    output pidFlags_t         flags,
    output logic [TimeW-1:0]  stamp,
    output logic [CountW-1:0] hitCount
);

    logic              sync0;
    logic              sync1;
    logic              sync2;
    logic              rise;
    logic              fall;
    logic [WidthW-1:0] widthCnt;
    logic [TimeW-1:0]  riseTime;

    function automatic logic inWindow(input logic [WidthW-1:0] width,
                                      input logic [WidthW-1:0] lo,
                                      input logic [WidthW-1:0] hi);
        return (width >= lo) && (width <= hi);
    endfunction

    assign rise = sync1 & ~sync2;
    assign fall = ~sync1 & sync2;

    // ------------------------------------------------------------------------
    // Synchronizer and width measurement
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            sync0    <= 1'b0;
            sync1    <= 1'b0;
            sync2    <= 1'b0;
            widthCnt <= '0;
        end else begin
            sync0 <= dIn;
            sync1 <= sync0;
            sync2 <= sync1;
            if (rise) begin
                widthCnt <= WidthW'(1);
            end else if (sync1 && widthCnt != '1) begin
                widthCnt <= widthCnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rise) begin
            riseTime <= timeNow;
        end
    end

    // ------------------------------------------------------------------------
    // Classification at the falling edge
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            flags    <= '0;
            stamp    <= '0;
            hitCount <= '0;
        end else begin
            flags <= '0;
            if (fall) begin
                flags.electron <= inWindow(widthCnt, windows.electronLo, windows.electronHi);
                flags.muon     <= inWindow(widthCnt, windows.muonLo, windows.muonHi);
                flags.pion     <= inWindow(widthCnt, windows.pionLo, windows.pionHi);
                stamp          <= riseTime;
            end
            // Clear wins over a hit in the same cycle
            if (countClear) begin
                hitCount <= '0;
            end else if (fall) begin
                hitCount <= hitCount + 1'b1;
            end
        end
    end

endmodule

// ==== verilog/particleCombiner.sv ====
// Group OR of the channel particle flags
// Totals over all groups, up from groups 0 and 2, down from groups 1 and 3
`timescale 1ns/1ps

module particleCombiner import fineTimePkg::*; #(
    parameter int NumChannels = 48,
    parameter int GroupSize   = 8
) (
    input  logic                              clk,
    input  logic                              arstN,
    input  pidFlags_t [NumChannels-1:0]       flags,
    output pidSummary_t                       summary
);

    localparam int NumGroups = NumChannels / GroupSize;

    pidFlags_t [NumGroups-1:0] groupFlags;
    pidSummary_t               summaryNext;

    always_comb begin
        groupFlags = '0;
        for (int c = 0; c < NumChannels; c++) begin
            groupFlags[c / GroupSize].electron |= flags[c].electron;
            groupFlags[c / GroupSize].muon     |= flags[c].muon;
            groupFlags[c / GroupSize].pion     |= flags[c].pion;
        end

        summaryNext = '0;
        for (int g = 0; g < NumGroups; g++) begin
            summaryNext.electron |= groupFlags[g].electron;
            summaryNext.muon     |= groupFlags[g].muon;
            summaryNext.pion     |= groupFlags[g].pion;
            if (g == 0 || g == 2) begin
                summaryNext.electronUp |= groupFlags[g].electron;
                summaryNext.muonUp     |= groupFlags[g].muon;
                summaryNext.pionUp     |= groupFlags[g].pion;
            end else if (g == 1 || g == 3) begin
                summaryNext.electronDown |= groupFlags[g].electron;
                summaryNext.muonDown     |= groupFlags[g].muon;
                summaryNext.pionDown     |= groupFlags[g].pion;
            end
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            summary <= '0;
        end else begin
            summary <= summaryNext;
        end
    end

endmodule

// ==== verilog/testMux.sv ====
// Two-stage registered test multiplexer for the channel time stamps
// Stage 1 picks within banks of 16, stage 2 picks the bank
`timescale 1ns/1ps

module testMux import fineTimePkg::*; #(
    parameter int NumChannels = 48
) (
    input  logic                              clk,
    input  logic                              arstN,
    input  logic [NumChannels-1:0][TimeW-1:0] stamps,
    input  logic [5:0]                        testChNum,
    output logic [TimeW-1:0]                  result
);

    localparam int BankSize = 16;
    localparam int NumBanks = 4;

    logic [NumBanks*BankSize-1:0][TimeW-1:0] stampPad;
    logic [NumBanks-1:0][TimeW-1:0]          bankQ;

    // Unused select codes see zero
    always_comb begin
        stampPad                   = '0;
        stampPad[NumChannels-1:0] = stamps;
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            bankQ <= '0;
        end else begin
            for (int b = 0; b < NumBanks; b++) begin
                bankQ[b] <= stampPad[b * BankSize + int'(testChNum[3:0])];
            end
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            result <= '0;
        end else begin
            result <= bankQ[testChNum[5:4]];
        end
    end

endmodule
